// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ble_at_receiver_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q -x '>>> PASS' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== at_response/at_response_fifo.sv ====
// ############################
// Response FIFO, byte writes packed into 16-bit words
// first byte of a pair lands in the upper half
// ############################
`timescale 1ns/1ps

module at_response_fifo import ble_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  wr_en,
	input  logic [BYTE_W-1:0]     wr_data,
	input  logic                  rd_en,
	output logic [WORD_W-1:0]     rd_data,
	output logic                  full,
	output logic                  empty,
	output logic [RD_COUNT_W-1:0] rd_count,
	output logic [WR_COUNT_W-1:0] wr_count
);

	logic [WORD_W-1:0] mem [FIFO_WORDS];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// Complete words held, 0 to FIFO_WORDS
	logic [PTR_W:0] word_cnt;

	// Upper half waiting for its partner
	logic              staged;
	logic [BYTE_W-1:0] stage_byte;

	logic wr_ok;
	logic commit;
	logic pop;

	// Bytes arriving at a full FIFO are dropped
	assign wr_ok = wr_en && !full;
	assign commit = wr_ok && staged;
	assign pop = rd_en && !empty;

	assign full = (word_cnt == (PTR_W+1)'(FIFO_WORDS));
	assign empty = (word_cnt == '0);

	// Counts saturate at all ones, since a full FIFO overflows both widths
	assign rd_count = word_cnt[PTR_W] ? '1 : word_cnt[RD_COUNT_W-1:0];
	assign wr_count = word_cnt[PTR_W] ? '1 : {word_cnt[WR_COUNT_W-2:0], staged};

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			word_cnt <= '0;
			staged <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				staged <= !staged;
			if (commit)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			// Push and pop in one cycle leave the count alone
			if (commit && !pop)
				word_cnt <= word_cnt + (PTR_W+1)'(1);
			else if (pop && !commit)
				word_cnt <= word_cnt - (PTR_W+1)'(1);
		end
	end

	// Storage and read register
	always_ff @(posedge clock)
	begin
		if (wr_ok && !staged)
			stage_byte <= wr_data;
		if (commit)
			mem[wr_ptr] <= {stage_byte, wr_data};
		if (pop)
			rd_data <= mem[rd_ptr];
	end

endmodule

// ==== at_response/handle_at_response.sv ====
// ############################
// AT response FSM; writes bytes while armed, ends a
// response on a quiet gap and pads odd byte counts
// ############################
`timescale 1ns/1ps

module handle_at_response import ble_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  logic               uart_done,
	input  logic               uart_collecting_data,
	input  logic [BYTE_W-1:0]  rx_byte,
	input  logic [TIMER_W-1:0] uart_cpd,
	input  logic [TIMER_W-1:0] uart_byte_spacing,
	output logic               wr_en,
	output logic [BYTE_W-1:0]  wr_data,
	output logic               at_response_flag
);

	atr_state_t state;
	atr_state_t state_next;

	// Gap timer
	logic [GAP_W-1:0] gap_limit;
	logic [GAP_W-1:0] gap_count;
	logic             gap_done;

	// Odd number of bytes stored in this response
	logic odd_bytes;

	logic byte_wr;
	logic pad_wr;

	// Two cpd periods cover the skew between uart_done, which comes
	// mid stop bit, and the next start edge, plus the byte spacing
	assign gap_limit = GAP_W'(uart_cpd) + GAP_W'(uart_byte_spacing) + GAP_W'(uart_cpd);
	assign gap_done = (gap_count >= gap_limit);

	// Bytes only count once armed
	assign byte_wr = uart_done && (state != ATR_IDLE);

	// Close the half word left by an odd response
	assign pad_wr = (state == ATR_PACKET_RECEIVED) && odd_bytes;

	assign wr_en = byte_wr || pad_wr;
	assign wr_data = pad_wr ? PAD_BYTE : rx_byte;

	assign at_response_flag = (state == ATR_PACKET_RECEIVED);

	always_comb
	begin
		state_next = state;
		case (state)
			ATR_IDLE:
			begin
				if (start)
					state_next = ATR_COLLECTING_DATA;
			end
			ATR_COLLECTING_DATA:
			begin
				if (uart_done)
					state_next = ATR_CHECKING_PACKET;
			end
			ATR_CHECKING_PACKET:
			begin
				// New start bit wins over an expiring timer
				if (uart_collecting_data)
					state_next = ATR_COLLECTING_DATA;
				else if (gap_done)
					state_next = ATR_PACKET_RECEIVED;
			end
			ATR_PACKET_RECEIVED:
			begin
				// Stay armed for the next response
				state_next = ATR_COLLECTING_DATA;
			end
			default:
			begin
				state_next = ATR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= ATR_IDLE;
		else
			state <= state_next;
	end

	// Counts only while checking for the end of a response
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			gap_count <= '0;
		else if (state == ATR_CHECKING_PACKET)
			gap_count <= gap_count + GAP_W'(1);
		else
			gap_count <= '0;
	end

	// Parity restarts with every response
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			odd_bytes <= 1'b0;
		else if (state == ATR_PACKET_RECEIVED)
			odd_bytes <= 1'b0;
		else if (byte_wr)
			odd_bytes <= !odd_bytes;
	end

endmodule

// ==== common/ble_pkg.sv ====
// ############################
// Shared widths, FIFO sizing and FSM state types
// for the BLE AT response receive path
// ############################

package ble_pkg;

	// Data path widths
	localparam int BYTE_W = 8;
	localparam int WORD_W = 16;

	// uart_cpd, uart_byte_spacing
	localparam int TIMER_W = 10;

	// Gap limit holds cpd + spacing + cpd without overflow
	localparam int GAP_W = 12;

	// Receive FIFO depth in 16-bit words, 256 bytes total
	localparam int FIFO_WORDS = 128;
	localparam int PTR_W = $clog2(FIFO_WORDS);

	// Status count widths, saturating at the top
	localparam int RD_COUNT_W = 7;
	localparam int WR_COUNT_W = 8;

	// Filler for the low half of an odd final word
	localparam logic [BYTE_W-1:0] PAD_BYTE = 8'h00;

	// Serial receiver
	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// AT response handler
	typedef enum logic [1:0]
	{
		ATR_IDLE,
		ATR_COLLECTING_DATA,
		ATR_CHECKING_PACKET,
		ATR_PACKET_RECEIVED
	} atr_state_t;

	// Host word reader
	typedef enum logic [1:0]
	{
		RD_WAIT_REQ,
		RD_FETCH,
		RD_ACK,
		RD_WAIT_RELEASE
	} rd_state_t;

endpackage

// ==== dv/ble_at_receiver_sva.sv ====
// ############################
// Handshake and flag assertions, bound into the
// response handler and the host word reader
// ############################
`timescale 1ns/1ps

module ble_at_receiver_sva import ble_pkg::*;
(
	input logic              clock,
	input logic              reset,
	input logic              rd_req,
	input logic              rd_ack,
	input logic [WORD_W-1:0] word,
	input logic              at_response_flag,
	input logic              wr_en,
	input logic              handler_idle
);

	// Ack only answers a pending request
	ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(rd_ack) |-> rd_req)
		else $error("rd_ack rose while rd_req was low");

	// Host samples word anywhere in the ack phase
	word_held: assert property (@(posedge clock) disable iff (reset)
		rd_ack ##1 rd_ack |-> $stable(word))
		else $error("word changed while rd_ack was high");

	// End of response is a single-cycle pulse
	flag_pulse: assert property (@(posedge clock) disable iff (reset)
		at_response_flag |=> !at_response_flag)
		else $error("at_response_flag high for more than one cycle");

	// Unarmed handler never touches the FIFO
	no_write_idle: assert property (@(posedge clock) disable iff (reset)
		!(wr_en && handler_idle))
		else $error("wr_en high while the handler is in IDLE");

endmodule

// Handler side, reader ports tied off
bind handle_at_response ble_at_receiver_sva u_handler_sva
(
	.clock            (clock),
	.reset            (reset),
	.rd_req           (1'b0),
	.rd_ack           (1'b0),
	.word             ('0),
	.at_response_flag (at_response_flag),
	.wr_en            (wr_en),
	.handler_idle     (state == ATR_IDLE)
);

// Reader side, handler ports tied off
bind response_reader ble_at_receiver_sva u_reader_sva
(
	.clock            (clock),
	.reset            (reset),
	.rd_req           (rd_req),
	.rd_ack           (rd_ack),
	.word             (word),
	.at_response_flag (1'b0),
	.wr_en            (1'b0),
	.handler_idle     (1'b0)
);

// ==== dv/ble_at_receiver_tb.sv ====
// ############################
// Directed testbench for the AT response receiver,
// serial bytes in, words read back over req/ack
// ############################
`timescale 1ns/1ps

module ble_at_receiver_tb import ble_pkg::*; ();

	// Bit time and byte spacing
	// Gap limit works out to 8 + 20 + 8 clocks
	localparam logic [TIMER_W-1:0] CPD = 10'd8;
	localparam logic [TIMER_W-1:0] SPACING = 10'd20;
	localparam int BIT_CLOCKS = 8;

	// Idle clocks after a stop bit either side of the gap limit
	localparam int SHORT_IDLE = 4;
	localparam int LONG_IDLE = 80;

	localparam int WAIT_LIMIT = 400;
	localparam int EMPTY_WAIT_LIMIT = 2000;
	localparam int RUN_LIMIT = 100000;
	localparam logic [31:0] SEED = 32'h27af_be99;

	logic                  clock;
	logic                  reset;
	logic                  rx;
	logic                  start;
	logic [TIMER_W-1:0]    uart_cpd;
	logic [TIMER_W-1:0]    uart_byte_spacing;
	logic                  rd_req;
	logic [WORD_W-1:0]     word;
	logic                  rd_ack;
	logic                  at_response_flag;
	logic [RD_COUNT_W-1:0] rd_count;
	logic [WR_COUNT_W-1:0] wr_count;
	logic                  full;
	logic                  empty;

	logic [31:0]       rng_state;
	logic [WORD_W-1:0] exp_q [$];
	logic [WORD_W-1:0] early_word;
	int                flag_pulses;
	int                flags_expected;

	ble_at_receiver DUT
	(
		.clock             (clock),
		.reset             (reset),
		.rx                (rx),
		.start             (start),
		.uart_cpd          (uart_cpd),
		.uart_byte_spacing (uart_byte_spacing),
		.rd_req            (rd_req),
		.word              (word),
		.rd_ack            (rd_ack),
		.at_response_flag  (at_response_flag),
		.rd_count          (rd_count),
		.wr_count          (wr_count),
		.full              (full),
		.empty             (empty)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Counts every flag pulse
	always @(negedge clock)
	begin
		if (!reset && at_response_flag)
			flag_pulses <= flag_pulses + 1;
	end

	// Run-wide backstop
	initial
	begin
		repeat (RUN_LIMIT) @(posedge clock);
		$display("Simulation ran past %0d clock cycles without finishing", RUN_LIMIT);
		abort_run();
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare_word(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_count(input string name, input logic [RD_COUNT_W-1:0] got,
		input logic [RD_COUNT_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_bytes(input string name, input logic [WR_COUNT_W-1:0] got,
		input logic [WR_COUNT_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// One bit cell starting just after a rising edge
	task automatic drive_bit(input logic value);
		@(posedge clock);
		#1 rx = value;
		repeat (BIT_CLOCKS - 1) @(posedge clock);
	endtask

	// 8N1 frame then idle_clocks of high line
	task automatic send_byte(input logic [BYTE_W-1:0] data, input int idle_clocks);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < BYTE_W; i++)
			drive_bit(data[i]);
		drive_bit(1'b1);
		repeat (idle_clocks) @(posedge clock);
	endtask

	// Random payload with expected words queued from byte pairs
	task automatic send_response(input int count, input int last_idle);
		logic [BYTE_W-1:0] resp [$];
		logic [BYTE_W-1:0] low;
		int i;
		for (i = 0; i < count; i++)
		begin
			rng_state = xorshift32(rng_state);
			resp.push_back(rng_state[BYTE_W-1:0]);
			send_byte(rng_state[BYTE_W-1:0], (i == count - 1) ? last_idle : SHORT_IDLE);
		end
		// First byte of a pair is the upper half and an odd tail gets the pad
		for (i = 0; i < count; i += 2)
		begin
			low = (i + 1 < count) ? resp[i + 1] : PAD_BYTE;
			exp_q.push_back({resp[i], low});
		end
	endtask

	task automatic wait_flag(input int limit);
		int n;
		n = 0;
		@(negedge clock);
		while (!at_response_flag && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (!at_response_flag)
		begin
			$display("No at_response_flag within %0d cycles", limit);
			abort_run();
		end
		flags_expected++;
		@(negedge clock);
		compare_flag("at_response_flag", at_response_flag, 1'b0);
	endtask

	// Four-phase host read
	task automatic read_word(output logic [WORD_W-1:0] data, input int limit);
		int n;
		@(posedge clock);
		#1 rd_req = 1'b1;
		n = 0;
		@(negedge clock);
		while (!rd_ack && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (!rd_ack)
		begin
			$display("No rd_ack within %0d cycles of rd_req", limit);
			abort_run();
		end
		data = word;
		@(posedge clock);
		#1 rd_req = 1'b0;
		n = 0;
		@(negedge clock);
		while (rd_ack && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (rd_ack)
		begin
			$display("rd_ack still high %0d cycles after rd_req fell", limit);
			abort_run();
		end
	endtask

	task automatic drain_and_check();
		logic [WORD_W-1:0] got;
		while (exp_q.size() > 0)
		begin
			read_word(got, WAIT_LIMIT);
			compare_word("word", got, exp_q.pop_front());
		end
		@(negedge clock);
		compare_flag("empty", empty, 1'b1);
	endtask

	task automatic check_flag_total();
		compare_count("flag pulse count", RD_COUNT_W'(flag_pulses), RD_COUNT_W'(flags_expected));
	endtask

	task automatic reset_and_unarmed();
		@(negedge clock);
		compare_flag("rd_ack", rd_ack, 1'b0);
		compare_flag("at_response_flag", at_response_flag, 1'b0);
		compare_flag("empty", empty, 1'b1);
		compare_count("rd_count", rd_count, RD_COUNT_W'(0));
		// Unarmed handler ignores both bytes
		send_byte(8'h41, LONG_IDLE);
		send_byte(8'h54, LONG_IDLE);
		@(negedge clock);
		compare_bytes("wr_count", wr_count, WR_COUNT_W'(0));
		check_flag_total();
		@(posedge clock);
		#1 start = 1'b1;
		@(posedge clock);
		#1 start = 1'b0;
	endtask

	task automatic even_response();
		send_response(6, SHORT_IDLE);
		wait_flag(WAIT_LIMIT);
		compare_count("rd_count", rd_count, RD_COUNT_W'(3));
		compare_bytes("wr_count", wr_count, WR_COUNT_W'(6));
		check_flag_total();
		drain_and_check();
	endtask

	task automatic odd_response_padded();
		send_response(5, SHORT_IDLE);
		// Fifth byte still staged until the flag brings the pad
		@(negedge clock);
		compare_bytes("wr_count", wr_count, WR_COUNT_W'(5));
		wait_flag(WAIT_LIMIT);
		compare_count("rd_count", rd_count, RD_COUNT_W'(3));
		compare_bytes("wr_count", wr_count, WR_COUNT_W'(6));
		check_flag_total();
		drain_and_check();
	endtask

	task automatic two_responses_in_order();
		// First flag fires inside the long idle
		send_response(3, LONG_IDLE);
		flags_expected++;
		send_response(4, SHORT_IDLE);
		wait_flag(WAIT_LIMIT);
		compare_count("rd_count", rd_count, RD_COUNT_W'(4));
		check_flag_total();
		drain_and_check();
	endtask

	task automatic read_before_data();
		compare_flag("empty", empty, 1'b1);
		fork
			read_word(early_word, EMPTY_WAIT_LIMIT);
			begin
				repeat (20)
				begin
					@(negedge clock);
					compare_flag("rd_ack", rd_ack, 1'b0);
				end
				send_response(2, SHORT_IDLE);
				wait_flag(WAIT_LIMIT);
			end
		join
		compare_word("word", early_word, exp_q.pop_front());
		check_flag_total();
		drain_and_check();
	endtask

	task automatic overflow_drops_bytes();
		send_response(2 * FIFO_WORDS + 4, SHORT_IDLE);
		wait_flag(WAIT_LIMIT);
		// Bytes past 256 never reach the FIFO
		while (exp_q.size() > FIFO_WORDS)
			void'(exp_q.pop_back());
		compare_flag("full", full, 1'b1);
		check_flag_total();
		drain_and_check();
		compare_flag("full", full, 1'b0);
	endtask

	initial
	begin
		reset = 1'b1;
		rx = 1'b1;
		start = 1'b0;
		rd_req = 1'b0;
		uart_cpd = CPD;
		uart_byte_spacing = SPACING;
		rng_state = SEED;
		flags_expected = 0;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;

		reset_and_unarmed();
		even_response();
		odd_response_padded();
		two_responses_in_order();
		read_before_data();
		overflow_drops_bytes();

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== files.f ====
common/ble_pkg.sv
uart_rx/uart_rx.sv
at_response/at_response_fifo.sv
at_response/handle_at_response.sv
rtl/response_reader.sv
rtl/ble_at_receiver.sv
dv/ble_at_receiver_sva.sv
dv/ble_at_receiver_tb.sv

// ==== rtl/ble_at_receiver.sv ====
// ############################
// BLE AT response receiver top, serial in, words out
// ############################
`timescale 1ns/1ps

module ble_at_receiver import ble_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  rx,
	input  logic                  start,
	input  logic [TIMER_W-1:0]    uart_cpd,
	input  logic [TIMER_W-1:0]    uart_byte_spacing,
	input  logic                  rd_req,
	output logic [WORD_W-1:0]     word,
	output logic                  rd_ack,
	output logic                  at_response_flag,
	output logic [RD_COUNT_W-1:0] rd_count,
	output logic [WR_COUNT_W-1:0] wr_count,
	output logic                  full,
	output logic                  empty
);

	// Receiver to handler
	logic [BYTE_W-1:0] rx_byte;
	logic              uart_done;
	logic              uart_collecting_data;

	// Handler to FIFO
	logic              wr_en;
	logic [BYTE_W-1:0] wr_data;

	// FIFO to reader
	logic              rd_en;
	logic [WORD_W-1:0] rd_data;

	uart_rx u_uart_rx
	(
		.clock                (clock),
		.reset                (reset),
		.rx                   (rx),
		.uart_cpd             (uart_cpd),
		.rx_byte              (rx_byte),
		.uart_done            (uart_done),
		.uart_collecting_data (uart_collecting_data)
	);

	handle_at_response u_handle_at_response
	(
		.clock                (clock),
		.reset                (reset),
		.start                (start),
		.uart_done            (uart_done),
		.uart_collecting_data (uart_collecting_data),
		.rx_byte              (rx_byte),
		.uart_cpd             (uart_cpd),
		.uart_byte_spacing    (uart_byte_spacing),
		.wr_en                (wr_en),
		.wr_data              (wr_data),
		.at_response_flag     (at_response_flag)
	);

	at_response_fifo u_at_response_fifo
	(
		.clock    (clock),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_data  (rd_data),
		.full     (full),
		.empty    (empty),
		.rd_count (rd_count),
		.wr_count (wr_count)
	);

	response_reader u_response_reader
	(
		.clock   (clock),
		.reset   (reset),
		.rd_req  (rd_req),
		.empty   (empty),
		.rd_data (rd_data),
		.rd_en   (rd_en),
		.rd_ack  (rd_ack),
		.word    (word)
	);

endmodule

// ==== rtl/response_reader.sv ====
// ############################
// Four-phase req/ack host port, one FIFO word per handshake
// ############################
`timescale 1ns/1ps

module response_reader import ble_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic              rd_req,
	input  logic              empty,
	input  logic [WORD_W-1:0] rd_data,
	output logic              rd_en,
	output logic              rd_ack,
	output logic [WORD_W-1:0] word
);

	rd_state_t state;
	rd_state_t state_next;

	// Pop as soon as a request meets a non-empty FIFO
	assign rd_en = (state == RD_WAIT_REQ) && rd_req && !empty;

	assign rd_ack = (state == RD_ACK);

	always_comb
	begin
		state_next = state;
		case (state)
			RD_WAIT_REQ:
			begin
				// Empty FIFO holds the request pending
				if (rd_en)
					state_next = RD_FETCH;
			end
			RD_FETCH:
			begin
				// rd_data valid this cycle
				state_next = RD_ACK;
			end
			RD_ACK:
			begin
				if (!rd_req)
					state_next = RD_WAIT_RELEASE;
			end
			RD_WAIT_RELEASE:
			begin
				// Ack is low again, next request may start
				state_next = RD_WAIT_REQ;
			end
			default:
			begin
				state_next = RD_WAIT_REQ;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= RD_WAIT_REQ;
		else
			state <= state_next;
	end

	// Word held steady through the ack phase
	always_ff @(posedge clock)
	begin
		if (state == RD_FETCH)
			word <= rd_data;
	end

endmodule

// ==== uart_rx/uart_rx.sv ====
// ############################
// 8N1 serial receiver, bit time set at run time
// by uart_cpd clocks per bit
// ############################
`timescale 1ns/1ps

module uart_rx import ble_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               rx,
	input  logic [TIMER_W-1:0] uart_cpd,
	output logic [BYTE_W-1:0]  rx_byte,
	output logic               uart_done,
	output logic               uart_collecting_data
);

	rx_state_t state;

	// Two-flop synchronizer plus one delayed copy for edge detect
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;

	logic [TIMER_W-1:0] bit_count;
	logic [2:0]         bit_index;
	logic [BYTE_W-1:0]  shift;

	logic start_edge;
	logic bit_end;
	logic half_bit;

	// Line idles high, start bit is the first falling edge
	assign start_edge = rx_prev && !rx_sync;

	// Middle of a full bit period, counted from the previous middle
	assign bit_end = (bit_count == uart_cpd - TIMER_W'(1));

	// Middle of the start bit
	assign half_bit = (bit_count == (uart_cpd >> 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			bit_count <= '0;
			bit_index <= '0;
			uart_done <= 1'b0;
			uart_collecting_data <= 1'b0;
		end
		else
		begin
			// Single-cycle pulse by default
			uart_done <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					bit_count <= '0;
					bit_index <= '0;
					if (start_edge)
					begin
						state <= RX_START;
						uart_collecting_data <= 1'b1;
					end
				end
				RX_START:
				begin
					if (half_bit)
					begin
						bit_count <= '0;
						// Glitch shorter than half a bit, back to idle
						if (rx_sync)
						begin
							state <= RX_IDLE;
							uart_collecting_data <= 1'b0;
						end
						else
							state <= RX_DATA;
					end
					else
						bit_count <= bit_count + TIMER_W'(1);
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						bit_count <= '0;
						bit_index <= bit_index + 3'd1;
						if (bit_index == 3'd7)
							state <= RX_STOP;
					end
					else
						bit_count <= bit_count + TIMER_W'(1);
				end
				RX_STOP:
				begin
					if (bit_end)
					begin
						state <= RX_IDLE;
						uart_collecting_data <= 1'b0;
						// Bad stop bit drops the byte silently
						uart_done <= rx_sync;
					end
					else
						bit_count <= bit_count + TIMER_W'(1);
				end
				default:
				begin
					state <= RX_IDLE;
					uart_collecting_data <= 1'b0;
				end
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_sync, shift[BYTE_W-1:1]};
		if (state == RX_STOP && bit_end && rx_sync)
			rx_byte <= shift;
	end

endmodule
